/* flist.f */
+incdir+.
game_pkg.sv
game_bus_decode.sv
game_mem_exec.sv
game_read_mux.sv
game_board.sv
game_board_assert.sv
game_board_tb.sv

/* game_board.sv */
/*
 * Game board core top level
 * Main CPU bus over APB with decode, execute and result stages
 */
`timescale 1ns/1ns

module game_board (
    input  logic                 clk,
    input  logic                 rst,
    // APB completer
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  game_pkg::cpu_addr_t  paddr,
    input  game_pkg::cpu_data_t  pwdata,
    input  game_pkg::byte_en_t   pstrb,
    output logic                 pready,
    output game_pkg::cpu_data_t  prdata,
    output logic                 pslverr,
    // Sound CPU side
    input  logic                 snd_rd,
    input  game_pkg::snd_byte_t  snd_reply,
    output game_pkg::snd_byte_t  snd_latch,
    output logic                 snd_pbf,
    // Video control
    output logic                 video_en,
    output logic                 flip,
    // Status dump
    input  game_pkg::st_addr_t   st_addr,
    output game_pkg::st_data_t   st_dout
);
    import game_pkg::*;

    logic       sel_ram, sel_pal, sel_ctrl, sel_latch, sel_reply;
    logic       unmapped, wr_go, rd_done, pbf_q;
    ram_idx_t   ram_idx;
    pal_idx_t   pal_idx;
    cpu_data_t  ram_rdata, pal_rdata, last_ram_q;
    logic [1:0] ctrl_q;
    snd_byte_t  latch_q;

    assign video_en  = ctrl_q[0];
    assign flip      = ctrl_q[1];
    assign snd_latch = latch_q;
    assign snd_pbf   = pbf_q;

    game_bus_decode u_decode (
        .clk        ( clk        ),  .rst        ( rst        ),
        .psel       ( psel       ),  .penable    ( penable    ),
        .pwrite     ( pwrite     ),  .paddr      ( paddr      ),
        .pready     ( pready     ),  .sel_ram    ( sel_ram    ),
        .sel_pal    ( sel_pal    ),  .sel_ctrl   ( sel_ctrl   ),
        .sel_latch  ( sel_latch  ),  .sel_reply  ( sel_reply  ),
        .unmapped   ( unmapped   ),  .wr_go      ( wr_go      ),
        .rd_done    ( rd_done    ),  .ram_idx    ( ram_idx    ),
        .pal_idx    ( pal_idx    )
    );

    game_mem_exec u_exec (
        .clk        ( clk        ),  .rst        ( rst        ),
        .sel_ram    ( sel_ram    ),  .sel_pal    ( sel_pal    ),
        .sel_ctrl   ( sel_ctrl   ),  .sel_latch  ( sel_latch  ),
        .wr_go      ( wr_go      ),  .rd_done    ( rd_done    ),
        .ram_idx    ( ram_idx    ),  .pal_idx    ( pal_idx    ),
        .pwdata     ( pwdata     ),  .pstrb      ( pstrb      ),
        .snd_rd     ( snd_rd     ),  .ram_rdata  ( ram_rdata  ),
        .pal_rdata  ( pal_rdata  ),  .last_ram_q ( last_ram_q ),
        .ctrl_q     ( ctrl_q     ),  .latch_q    ( latch_q    ),
        .pbf_q      ( pbf_q      )
    );

    game_read_mux u_result (
        .clk        ( clk        ),  .rst        ( rst        ),
        .sel_ram    ( sel_ram    ),  .sel_pal    ( sel_pal    ),
        .sel_ctrl   ( sel_ctrl   ),  .sel_latch  ( sel_latch  ),
        .sel_reply  ( sel_reply  ),  .unmapped   ( unmapped   ),
        .ram_rdata  ( ram_rdata  ),  .pal_rdata  ( pal_rdata  ),
        .last_ram_q ( last_ram_q ),  .ctrl_q     ( ctrl_q     ),
        .latch_q    ( latch_q    ),  .pbf_q      ( pbf_q      ),
        .snd_reply  ( snd_reply  ),  .st_addr    ( st_addr    ),
        .prdata     ( prdata     ),  .pslverr    ( pslverr    ),
        .st_dout    ( st_dout    )
    );

endmodule

/* game_board_assert.sv */
/*
 * Bound checks for the game board core
 * APB handshake, error response and sound mailbox flag rules
 */
`timescale 1ns/1ns
`include "game_config.svh"

module game_board_assert (
    input logic                clk,
    input logic                rst,
    input logic                psel,
    input logic                penable,
    input logic                pwrite,
    input game_pkg::cpu_addr_t paddr,
    input game_pkg::byte_en_t  pstrb,
    input logic                pready,
    input logic                pslverr,
    input logic                snd_pbf
);
    import game_pkg::*;

    // Number of failed assertions
    int         fail_cnt = 0;
    apb_phase_t phase_q;

    // Master phase tracked apart from the decoder
    always_ff @(posedge clk) begin
        if (rst || !psel) begin
            phase_q <= IDLE;
        end else if (!penable) begin
            phase_q <= SETUP;
        end else begin
            phase_q <= pready ? IDLE : ACCESS;
        end
    end

    err_in_xfer: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable && pready))
        else begin
            $error("pslverr high outside a completing transfer");
            fail_cnt++;
        end

    ready_in_access: assert property (@(posedge clk) disable iff (rst)
        pready |-> (psel && penable && (phase_q != IDLE)))
        else begin
            $error("pready high outside an access cycle");
            fail_cnt++;
        end

    // Flag may only rise one edge after a mailbox write completed
    pbf_after_write: assert property (@(posedge clk) disable iff (rst)
        $rose(snd_pbf) |-> $past(psel && penable && pready && pwrite
                                 && (paddr == `GAME_LATCH_ADDR) && pstrb[0]))
        else begin
            $error("snd_pbf rose without a mailbox write");
            fail_cnt++;
        end

endmodule

/* game_board_tb.sv */
/*
 * Directed testbench for the game board core
 * Drives the APB and sound side, models both RAMs and checks every result
 */
`timescale 1ns/1ns
`include "game_config.svh"

module game_board_tb;
    import game_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int N_RAM       = 20;
    localparam int N_PAL       = 12;
    // Reset, control, mailbox and out of range accesses add the constant
    localparam int N_XFER      = 2 * N_RAM + 3 * N_PAL + 24;
    localparam int WATCHDOG_NS = (N_XFER * 10 + 200) * CLK_PERIOD;
    localparam cpu_addr_t PAL_PAST = `GAME_PAL_BASE + 2 * `GAME_PAL_WORDS;

    logic      clk = 1'b0;
    logic      rst, psel, penable, pwrite, pready, pslverr;
    cpu_addr_t paddr;
    cpu_data_t pwdata, prdata;
    byte_en_t  pstrb;
    logic      snd_rd, snd_pbf, video_en, flip;
    snd_byte_t snd_reply, snd_latch;
    st_addr_t  st_addr;
    st_data_t  st_dout;

    // Scoreboard
    cpu_data_t  ram_model [`GAME_RAM_WORDS];
    cpu_data_t  pal_model [`GAME_PAL_WORDS];
    cpu_data_t  last_read = '0;
    logic [1:0] ctrl_model = 2'b00;
    snd_byte_t  latch_model = '0;
    int         checks = 0;
    int         errors = 0;

    game_board game_board_i (.*);

    bind game_board game_board_assert u_assert (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_word(input string name, input cpu_data_t got, input cpu_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_byte(input string name, input st_data_t got, input st_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            $display("%s finished with no errors", name);
        end else begin
            $display("%s finished with %0d errors", name, errors - err_start);
        end
    endtask

    function automatic cpu_data_t merge_bytes(cpu_data_t old_w, cpu_data_t new_w, byte_en_t strb);
        cpu_data_t res;
        res = old_w;
        for (int b = 0; b < $bits(byte_en_t); b++) begin
            if (strb[b]) begin
                res[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic cpu_addr_t pal_addr(pal_idx_t idx);
        return `GAME_PAL_BASE + cpu_addr_t'({idx, 1'b0});
    endfunction

    // One APB transfer where snd_strobe raises snd_rd for the first access cycle
    task automatic bus_transfer(input logic write, input cpu_addr_t addr,
                                input cpu_data_t wdata, input byte_en_t strb,
                                input logic snd_strobe,
                                output cpu_data_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr;
        pwdata  <= wdata;
        pstrb   <= strb;
        @(posedge clk);
        penable <= 1'b1;
        snd_rd  <= snd_strobe;
        @(negedge clk);
        while (!pready) begin
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        snd_rd  <= 1'b0;
    endtask

    task automatic apb_write(input cpu_addr_t addr, input cpu_data_t wdata,
                             input byte_en_t strb, input logic exp_err);
        cpu_data_t rdata;
        logic      err;
        bus_transfer(1'b1, addr, wdata, strb, 1'b0, rdata, err);
        check_bit("pslverr", err, exp_err);
    endtask

    task automatic apb_read(input cpu_addr_t addr, output cpu_data_t rdata, output logic err);
        bus_transfer(1'b0, addr, '0, '0, 1'b0, rdata, err);
    endtask

    task automatic read_check(input cpu_addr_t addr, input cpu_data_t exp);
        cpu_data_t rdata;
        logic      err;
        apb_read(addr, rdata, err);
        check_word("prdata", rdata, exp);
        check_bit("pslverr", err, 1'b0);
    endtask

    // st_dout is registered, so it answers one edge after st_addr
    task automatic dump_check(input st_addr_t addr, input st_data_t exp);
        @(posedge clk);
        st_addr <= addr;
        @(posedge clk);
        @(negedge clk);
        check_byte("st_dout", st_dout, exp);
    endtask

    task automatic sound_read();
        @(posedge clk);
        snd_rd <= 1'b1;
        @(posedge clk);
        snd_rd <= 1'b0;
        @(negedge clk);
    endtask

    task automatic reset_values();
        int err_start;
        err_start = errors;
        @(negedge clk);
        check_bit("video_en", video_en, 1'b0);
        check_bit("flip", flip, 1'b0);
        check_bit("snd_pbf", snd_pbf, 1'b0);
        check_byte("snd_latch", snd_latch, '0);
        check_bit("pready", pready, 1'b0);
        check_byte("st_dout", st_dout, '0);
        read_check(`GAME_CTRL_ADDR, '0);
        read_check(`GAME_LATCH_ADDR, '0);
        report_test("reset values", err_start);
    endtask

    task automatic work_ram_rw();
        int        err_start;
        bit        seen [`GAME_RAM_WORDS];
        ram_idx_t  written [$];
        ram_idx_t  idx;
        cpu_data_t wdata;
        byte_en_t  strb;
        err_start = errors;
        for (int i = 0; i < N_RAM; i++) begin
            idx   = ram_idx_t'($urandom_range(`GAME_RAM_WORDS - 1));
            wdata = cpu_data_t'($urandom);
            strb  = byte_en_t'($urandom_range(3));
            // First write to a word fills both bytes
            if (!seen[idx]) begin
                strb      = '1;
                seen[idx] = 1'b1;
                written.push_back(idx);
            end
            apb_write(cpu_addr_t'({idx, 1'b0}), wdata, strb, 1'b0);
            ram_model[idx] = merge_bytes(ram_model[idx], wdata, strb);
        end
        foreach (written[i]) begin
            read_check(cpu_addr_t'({written[i], 1'b0}), ram_model[written[i]]);
            last_read = ram_model[written[i]];
        end
        dump_check({3'd3, 5'($urandom)}, last_read[7:0]);
        dump_check({3'd4, 5'($urandom)}, last_read[15:8]);
        report_test("work RAM", err_start);
    endtask

    task automatic palette_rw();
        int        err_start;
        bit        seen [`GAME_PAL_WORDS];
        pal_idx_t  written [$];
        pal_idx_t  idx;
        cpu_data_t wdata;
        cpu_data_t rdata;
        byte_en_t  strb;
        logic      err;
        err_start = errors;
        for (int i = 0; i < N_PAL; i++) begin
            // Word 0 is where an address just past the range would alias
            idx   = (i == 0) ? '0 : pal_idx_t'($urandom_range(`GAME_PAL_WORDS - 1));
            wdata = cpu_data_t'($urandom);
            strb  = byte_en_t'($urandom_range(3));
            if (!seen[idx]) begin
                strb      = '1;
                seen[idx] = 1'b1;
                written.push_back(idx);
            end
            apb_write(pal_addr(idx), wdata, strb, 1'b0);
            pal_model[idx] = merge_bytes(pal_model[idx], wdata, strb);
        end
        foreach (written[i]) begin
            read_check(pal_addr(written[i]), pal_model[written[i]]);
        end
        apb_write(PAL_PAST, 16'hDEAD, 2'b11, 1'b1);
        apb_read(PAL_PAST, rdata, err);
        check_word("prdata", rdata, '0);
        check_bit("pslverr", err, 1'b1);
        foreach (written[i]) begin
            read_check(pal_addr(written[i]), pal_model[written[i]]);
        end
        report_test("palette", err_start);
    endtask

    task automatic ctrl_step(input cpu_data_t wdata, input byte_en_t strb);
        apb_write(`GAME_CTRL_ADDR, wdata, strb, 1'b0);
        if (strb[0]) begin
            ctrl_model = wdata[1:0];
        end
        @(negedge clk);
        check_bit("video_en", video_en, ctrl_model[0]);
        check_bit("flip", flip, ctrl_model[1]);
        read_check(`GAME_CTRL_ADDR, {14'd0, ctrl_model});
    endtask

    task automatic control_reg();
        int err_start;
        err_start = errors;
        ctrl_step(16'hFFFF, 2'b11);
        ctrl_step(16'h0002, 2'b01);
        ctrl_step(16'h0001, 2'b10);
        ctrl_step(16'h00FD, 2'b01);
        report_test("control register", err_start);
    endtask

    task automatic mailbox_flow();
        int        err_start;
        cpu_data_t rdata;
        logic      err;
        snd_byte_t reply_val;
        err_start = errors;
        apb_write(`GAME_LATCH_ADDR, 16'h12A5, 2'b11, 1'b0);
        @(negedge clk);
        check_byte("snd_latch", snd_latch, 8'hA5);
        check_bit("snd_pbf", snd_pbf, 1'b1);
        read_check(`GAME_LATCH_ADDR, 16'h80A5);
        // Overwrite while still full
        apb_write(`GAME_LATCH_ADDR, 16'h335C, 2'b01, 1'b0);
        @(negedge clk);
        check_byte("snd_latch", snd_latch, 8'h5C);
        check_bit("snd_pbf", snd_pbf, 1'b1);
        sound_read();
        check_bit("snd_pbf", snd_pbf, 1'b0);
        read_check(`GAME_LATCH_ADDR, 16'h005C);
        // Sound read on the completing edge of a write that still wins
        bus_transfer(1'b1, `GAME_LATCH_ADDR, 16'h0077, 2'b11, 1'b1, rdata, err);
        check_bit("pslverr", err, 1'b0);
        @(negedge clk);
        check_bit("snd_pbf", snd_pbf, 1'b1);
        check_byte("snd_latch", snd_latch, 8'h77);
        latch_model = 8'h77;
        sound_read();
        check_bit("snd_pbf", snd_pbf, 1'b0);
        reply_val = snd_byte_t'($urandom);
        @(posedge clk);
        snd_reply <= reply_val;
        read_check(`GAME_REPLY_ADDR, {8'd0, reply_val});
        apb_write(`GAME_REPLY_ADDR, 16'hFFFF, 2'b11, 1'b0);
        read_check(`GAME_REPLY_ADDR, {8'd0, reply_val});
        report_test("mailbox", err_start);
    endtask

    task automatic status_dump_groups();
        int       err_start;
        st_addr_t addr;
        st_data_t exp;
        err_start = errors;
        for (int g = 0; g < 8; g++) begin
            addr = {3'(g), 5'($urandom)};
            case (g)
                0:       exp = {6'd0, ctrl_model};
                1:       exp = latch_model;
                2:       exp = snd_reply;
                3:       exp = last_read[7:0];
                4:       exp = last_read[15:8];
                default: exp = addr;
            endcase
            dump_check(addr, exp);
        end
        report_test("status dump", err_start);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(7));
        rst       = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        pstrb     = '0;
        snd_rd    = 1'b0;
        snd_reply = '0;
        st_addr   = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        reset_values();
        work_ram_rw();
        palette_rw();
        control_reg();
        mailbox_flow();
        status_dump_groups();
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, game_board_i.u_assert.fail_cnt);
        if (errors == 0 && game_board_i.u_assert.fail_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* game_bus_decode.sv */
/*
 * Main CPU bus decode stage
 * APB completer front end, region selects, wait states and error flag
 */
`timescale 1ns/1ns
`include "game_config.svh"

module game_bus_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  game_pkg::cpu_addr_t  paddr,
    output logic                 pready,
    output logic                 sel_ram,
    output logic                 sel_pal,
    output logic                 sel_ctrl,
    output logic                 sel_latch,
    output logic                 sel_reply,
    output logic                 unmapped,
    output logic                 wr_go,
    output logic                 rd_done,
    output game_pkg::ram_idx_t   ram_idx,
    output game_pkg::pal_idx_t   pal_idx
);
    import game_pkg::*;

    // First byte address past each memory region
    localparam cpu_addr_t RAM_END = cpu_addr_t'(`GAME_RAM_WORDS * 2);
    localparam cpu_addr_t PAL_END = cpu_addr_t'(`GAME_PAL_BASE + `GAME_PAL_WORDS * 2);

    apb_phase_t phase_q;
    logic       wait_q;
    logic       in_access;
    logic       mem_sel;
    cpu_addr_t  pal_off;

    // Region decode on the held address
    assign sel_ram   = paddr < RAM_END;
    assign sel_pal   = (paddr >= `GAME_PAL_BASE) && (paddr < PAL_END);
    assign sel_ctrl  = paddr == `GAME_CTRL_ADDR;
    assign sel_latch = paddr == `GAME_LATCH_ADDR;
    assign sel_reply = paddr == `GAME_REPLY_ADDR;

    assign pal_off = paddr - `GAME_PAL_BASE;
    assign ram_idx = paddr[$bits(ram_idx_t):1];
    assign pal_idx = pal_off[$bits(pal_idx_t):1];

    // An enable without a prior setup cycle is not an access
    assign in_access = psel && penable && (phase_q != IDLE);
    assign mem_sel   = sel_ram || sel_pal;

    // Memory reads are registered, so they need one extra access cycle
    assign pready  = in_access && (!mem_sel || wait_q);
    assign wr_go   = pready && pwrite;
    assign rd_done = pready && !pwrite;

    // Only valid on the completing cycle, which drives pslverr directly
    assign unmapped = pready && !(mem_sel || sel_ctrl || sel_latch || sel_reply);

    always_ff @(posedge clk) begin
        if (rst) begin
            phase_q <= IDLE;
            wait_q  <= 1'b0;
        end else begin
            // Set during a stalled memory access cycle
            wait_q <= in_access && mem_sel && !pready;
            case (phase_q)
                IDLE: begin
                    if (psel && !penable) begin
                        phase_q <= SETUP;
                    end
                end
                SETUP: begin
                    if (!psel) begin
                        phase_q <= IDLE;
                    end else if (penable) begin
                        phase_q <= pready ? IDLE : ACCESS;
                    end
                end
                ACCESS: begin
                    if (!psel || pready) begin
                        phase_q <= IDLE;
                    end
                end
                default: phase_q <= IDLE;
            endcase
        end
    end

endmodule

/* game_config.svh */
/*
 * Game board core configuration
 * Bus widths, memory depths and the CPU address map
 */
`ifndef GAME_CONFIG_SVH
`define GAME_CONFIG_SVH

// CPU bus widths
`define GAME_ADDR_W      16
`define GAME_DATA_W      16

// Memory depths in 16-bit words
`define GAME_RAM_WORDS   256
`define GAME_PAL_WORDS   64

// Byte addresses of the palette and the registers
`define GAME_PAL_BASE    16'h0400
`define GAME_CTRL_ADDR   16'h0800
`define GAME_LATCH_ADDR  16'h0802
`define GAME_REPLY_ADDR  16'h0804

`endif

/* game_mem_exec.sv */
/*
 * Main CPU bus execute stage
 * Work RAM, palette RAM, video control register and sound mailbox
 */
`timescale 1ns/1ns
`include "game_config.svh"

module game_mem_exec (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sel_ram,
    input  logic                 sel_pal,
    input  logic                 sel_ctrl,
    input  logic                 sel_latch,
    input  logic                 wr_go,
    input  logic                 rd_done,
    input  game_pkg::ram_idx_t   ram_idx,
    input  game_pkg::pal_idx_t   pal_idx,
    input  game_pkg::cpu_data_t  pwdata,
    input  game_pkg::byte_en_t   pstrb,
    input  logic                 snd_rd,
    output game_pkg::cpu_data_t  ram_rdata,
    output game_pkg::cpu_data_t  pal_rdata,
    output game_pkg::cpu_data_t  last_ram_q,
    output logic [1:0]           ctrl_q,
    output game_pkg::snd_byte_t  latch_q,
    output logic                 pbf_q
);
    import game_pkg::*;

    cpu_data_t ram_mem [`GAME_RAM_WORDS];
    cpu_data_t pal_mem [`GAME_PAL_WORDS];

    logic ram_we;
    logic pal_we;
    logic ctrl_we;
    logic latch_we;

    // Registers only look at the low byte lane
    assign ram_we   = wr_go && sel_ram;
    assign pal_we   = wr_go && sel_pal;
    assign ctrl_we  = wr_go && sel_ctrl && pstrb[0];
    assign latch_we = wr_go && sel_latch && pstrb[0];

    // Work RAM with byte lanes following pstrb
    always_ff @(posedge clk) begin
        if (ram_we) begin
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (pstrb[b]) begin
                    ram_mem[ram_idx][b*8 +: 8] <= pwdata[b*8 +: 8];
                end
            end
        end
        ram_rdata <= ram_mem[ram_idx];
    end

    // Palette RAM
    always_ff @(posedge clk) begin
        if (pal_we) begin
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (pstrb[b]) begin
                    pal_mem[pal_idx][b*8 +: 8] <= pwdata[b*8 +: 8];
                end
            end
        end
        pal_rdata <= pal_mem[pal_idx];
    end

    // Last completed work RAM read word for the status dump
    always_ff @(posedge clk) begin
        if (rd_done && sel_ram) begin
            last_ram_q <= ram_rdata;
        end
    end

    // Video control with bit 0 as video enable and bit 1 as screen flip
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_q <= 2'b00;
        end else if (ctrl_we) begin
            ctrl_q <= pwdata[1:0];
        end
    end

    // Sound mapper mailbox
    always_ff @(posedge clk) begin
        if (rst) begin
            latch_q <= '0;
        end else if (latch_we) begin
            latch_q <= pwdata[7:0];
        end
    end

    // Full flag where a main CPU write beats the sound CPU read
    always_ff @(posedge clk) begin
        if (rst) begin
            pbf_q <= 1'b0;
        end else if (latch_we) begin
            pbf_q <= 1'b1;
        end else if (snd_rd) begin
            pbf_q <= 1'b0;
        end
    end

endmodule

/* game_pkg.sv */
/*
 * Game board core types
 * Bus, memory index, sound and status dump vectors plus the APB phase enum
 */
`include "game_config.svh"

package game_pkg;

    // CPU bus
    typedef logic [`GAME_ADDR_W-1:0]   cpu_addr_t;
    typedef logic [`GAME_DATA_W-1:0]   cpu_data_t;
    typedef logic [`GAME_DATA_W/8-1:0] byte_en_t;

    // Word indices into the two RAMs
    typedef logic [$clog2(`GAME_RAM_WORDS)-1:0] ram_idx_t;
    typedef logic [$clog2(`GAME_PAL_WORDS)-1:0] pal_idx_t;

    // Sound mapper bytes
    typedef logic [7:0] snd_byte_t;

    // Status dump port
    typedef logic [7:0] st_addr_t;
    typedef logic [7:0] st_data_t;

    // Where a transfer stands on the APB
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } apb_phase_t;

endpackage

/* game_read_mux.sv */
/*
 * Main CPU bus result stage
 * Read data selection, error response and the status dump selector
 */
`timescale 1ns/1ns

module game_read_mux (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 sel_ram,
    input  logic                 sel_pal,
    input  logic                 sel_ctrl,
    input  logic                 sel_latch,
    input  logic                 sel_reply,
    input  logic                 unmapped,
    input  game_pkg::cpu_data_t  ram_rdata,
    input  game_pkg::cpu_data_t  pal_rdata,
    input  game_pkg::cpu_data_t  last_ram_q,
    input  logic [1:0]           ctrl_q,
    input  game_pkg::snd_byte_t  latch_q,
    input  logic                 pbf_q,
    input  game_pkg::snd_byte_t  snd_reply,
    input  game_pkg::st_addr_t   st_addr,
    output game_pkg::cpu_data_t  prdata,
    output logic                 pslverr,
    output game_pkg::st_data_t   st_dout
);
    import game_pkg::*;

    // Error only on the completing cycle of an unmapped access
    assign pslverr = unmapped;

    always_comb begin
        prdata = '0;
        if (sel_ram) begin
            prdata = ram_rdata;
        end else if (sel_pal) begin
            prdata = pal_rdata;
        end else if (sel_ctrl) begin
            prdata = cpu_data_t'(ctrl_q);
        end else if (sel_latch) begin
            // Flag sits in the top bit
            prdata = {pbf_q, 7'd0, latch_q};
        end else if (sel_reply) begin
            prdata = cpu_data_t'(snd_reply);
        end
    end

    // Status dump grouped by the top three address bits
    always_ff @(posedge clk) begin
        if (rst) begin
            st_dout <= '0;
        end else begin
            case (st_addr[7:5])
                3'd0:    st_dout <= st_data_t'(ctrl_q);
                3'd1:    st_dout <= latch_q;
                3'd2:    st_dout <= snd_reply;
                3'd3:    st_dout <= last_ram_q[7:0];
                3'd4:    st_dout <= last_ram_q[15:8];
                default: st_dout <= st_addr;
            endcase
        end
    end

endmodule
